// File: verilog.f
hw/uart_pkg.sv
hw/adc_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/adc_capture.sv
hw/report_sequencer.sv
hw/fpga_slave.sv
bench/fpga_slave_tb.sv

// File: Bender.yml
package:
  name: fpga_slave

sources:
  - files:
      - hw/uart_pkg.sv
      - hw/adc_pkg.sv
      - hw/uart_rx.sv
      - hw/uart_tx.sv
      - hw/adc_capture.sv
      - hw/report_sequencer.sv
      - hw/fpga_slave.sv
  - target: simulation
    files:
      - bench/fpga_slave_tb.sv

// File: bench/fpga_slave_tb.sv
module fpga_slave_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS_PER_BIT   = 16;
    localparam int REPORT_CYCLES  = 6000;
    localparam int SAMPLE_DIV     = 8;
    localparam int N_RAND         = 4;
    localparam int N_ROWS         = N_RAND + 2;   // random rows plus the two extremes
    localparam int TIMEOUT_CYCLES = (N_ROWS + 1) * (REPORT_CYCLES + 4000);

    logic               sys_clk;
    logic               sys_rst_n;
    logic               uart_rx;
    logic               uart_tx;
    adc_pkg::adc_code_t ad1_in;
    adc_pkg::adc_code_t ad2_in;

    // stimulus and expected values per report period
    adc_pkg::adc_code_t   ad1_tab  [N_ROWS];
    adc_pkg::adc_code_t   ad2_tab  [N_ROWS];
    int                   exp1_tab [N_ROWS];
    int                   exp2_tab [N_ROWS];
    uart_pkg::uart_byte_t echo_tab [N_ROWS][2];

    uart_pkg::uart_byte_t rx_q [$];   // frames decoded from uart_tx
    logic [31:0]          lcg_state = 32'hfcada5cc;
    int                   err_mismatch = 0;
    int                   err_other = 0;
    int                   cycle_cnt;

    fpga_slave
    #(
        .CLKS_PER_BIT  (CLKS_PER_BIT),
        .REPORT_CYCLES (REPORT_CYCLES),
        .SAMPLE_DIV    (SAMPLE_DIV)
    )
    dut_i
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .uart_rx   (uart_rx),
        .uart_tx   (uart_tx),
        .ad1_in    (ad1_in),
        .ad2_in    (ad2_in)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // millivolts from a raw code, rounded toward zero
    function automatic int scale_to_mv(input int code);
        return (code * adc_pkg::FULL_SCALE_MV) / (2 ** adc_pkg::ADC_CODE_BITS);
    endfunction

    function automatic byte hex_digit(input int nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[nib];
    endfunction

    function automatic string mv_hex(input int mv);
        return $sformatf("%c%c%c", hex_digit((mv >> 8) & 15), hex_digit((mv >> 4) & 15),
                         hex_digit(mv & 15));
    endfunction

    function automatic void fill_table();
        logic [31:0] rnd;
        for (int r = 0; r < N_RAND; r++)
        begin
            rnd = next_rand();
            ad1_tab[r] = rnd[27:16];
            rnd = next_rand();
            ad2_tab[r] = rnd[27:16];
            exp1_tab[r] = scale_to_mv(ad1_tab[r]);
            exp2_tab[r] = scale_to_mv(ad2_tab[r]);
            rnd = next_rand();
            echo_tab[r][0] = rnd[23:16];
            echo_tab[r][1] = rnd[31:24];
        end
        ad1_tab[N_RAND]      = 12'h000;   // extremes with literal expectations
        ad2_tab[N_RAND]      = 12'hFFF;
        exp1_tab[N_RAND]     = 12'h000;
        exp2_tab[N_RAND]     = 12'h7CF;
        echo_tab[N_RAND][0]  = 8'h55;
        echo_tab[N_RAND][1]  = 8'h0D;
        ad1_tab[N_RAND+1]    = 12'hFFF;
        ad2_tab[N_RAND+1]    = 12'h000;
        exp1_tab[N_RAND+1]   = 12'h7CF;
        exp2_tab[N_RAND+1]   = 12'h000;
        echo_tab[N_RAND+1][0] = 8'hFF;
        echo_tab[N_RAND+1][1] = 8'h00;
    endfunction

    // caller sits 1 ns after a rising edge
    task automatic send_uart_byte(input uart_pkg::uart_byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            uart_rx = frame[i];
            repeat (CLKS_PER_BIT) @(posedge sys_clk);
            #1;
        end
        repeat (10 * CLKS_PER_BIT) @(posedge sys_clk); // one idle frame between bytes
        #1;
    endtask

    task automatic next_decoded_byte(output uart_pkg::uart_byte_t b);
        while (rx_q.size() == 0)
            @(posedge sys_clk);
        b = rx_q.pop_front();
    endtask

    task automatic check_echo(input uart_pkg::uart_byte_t exp);
        uart_pkg::uart_byte_t got;
        next_decoded_byte(got);
        assert (got == exp)
        else
        begin
            $display("MISMATCH uart_tx echo byte: got 0x%02h, expected 0x%02h", got, exp);
            err_mismatch++;
        end
    endtask

    task automatic check_report(input int mv1, input int mv2);
        string                line;
        uart_pkg::uart_byte_t got;
        line = $sformatf("A1=%s A2=%s%c%c", mv_hex(mv1), mv_hex(mv2), 8'h0D, 8'h0A);
        for (int i = 0; i < uart_pkg::REPORT_LEN; i++)
        begin
            next_decoded_byte(got);
            assert (got == line[i])
            else
            begin
                $display("MISMATCH uart_tx report char %0d: got 0x%02h, expected 0x%02h",
                         i, got, line[i]);
                err_mismatch++;
            end
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    // frame decoder sampling at mid-bit on the falling clock edge
    initial
    begin : uart_monitor
        uart_pkg::uart_byte_t data;
        wait (sys_rst_n === 1'b1);
        forever
        begin
            @(negedge uart_tx);
            repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
            assert (uart_tx === 1'b0)
            else
            begin
                $display("ERROR: start bit on uart_tx went high before mid-bit");
                err_other++;
            end
            for (int i = 0; i < 8; i++)
            begin
                repeat (CLKS_PER_BIT) @(negedge sys_clk);
                data[i] = uart_tx;   // lsb first
            end
            repeat (CLKS_PER_BIT) @(negedge sys_clk);
            assert (uart_tx === 1'b1)
            else
            begin
                $display("ERROR: frame with data 0x%02h has a low stop bit on uart_tx", data);
                err_other++;
            end
            rx_q.push_back(data);
        end
    end

    initial
    begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge sys_clk);
            cycle_cnt++;
        end
        $display("ERROR: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        err_other++;
        finish_run();
    end

    initial
    begin : main_seq
        sys_rst_n = 1'b0;
        uart_rx   = 1'b1;
        ad1_in    = '0;
        ad2_in    = '0;
        fill_table();
        repeat (4)
        begin
            @(posedge sys_clk);
            #1;
            assert (uart_tx === 1'b1)
            else
            begin
                $display("ERROR: uart_tx is not idle high during reset");
                err_other++;
            end
        end
        sys_rst_n = 1'b1;

        // snapshot is taken before the first sample reaches the outputs
        check_report(0, 0);

        for (int r = 0; r < N_ROWS; r++)
        begin
            @(posedge sys_clk);
            #1;
            ad1_in = ad1_tab[r];
            ad2_in = ad2_tab[r];
            send_uart_byte(echo_tab[r][0]);
            send_uart_byte(echo_tab[r][1]);
            check_echo(echo_tab[r][0]);
            check_echo(echo_tab[r][1]);
            check_report(exp1_tab[r], exp2_tab[r]);
        end

        // the line stays quiet for two frame times after the last report
        repeat (20 * CLKS_PER_BIT) @(posedge sys_clk);
        assert (rx_q.size() == 0)
        else
        begin
            $display("ERROR: %0d unexpected extra frames on uart_tx", rx_q.size());
            err_other++;
        end
        finish_run();
    end

endmodule

// File: hw/fpga_slave.sv
module fpga_slave
#(
    parameter int CLKS_PER_BIT  = 868,
    parameter int REPORT_CYCLES = 100_000_000,
    parameter int SAMPLE_DIV    = 100
)
(
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  logic               uart_rx,
    output logic               uart_tx,
    input  adc_pkg::adc_code_t ad1_in,
    input  adc_pkg::adc_code_t ad2_in
);

    uart_pkg::uart_byte_t rx_data;
    logic                 rx_valid;
    uart_pkg::uart_byte_t tx_data;
    logic                 tx_valid;
    logic                 tx_ready;
    adc_pkg::millivolt_t  volt_ch1;
    adc_pkg::millivolt_t  volt_ch2;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rx_pin    (uart_rx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)  // always accepted, no back-pressure
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_pin    (uart_tx)
    );

    adc_capture #(.SAMPLE_DIV(SAMPLE_DIV)) adc_inst
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .ad1_in    (ad1_in),
        .ad2_in    (ad2_in),
        .volt_ch1  (volt_ch1),
        .volt_ch2  (volt_ch2)
    );

    report_sequencer #(.REPORT_CYCLES(REPORT_CYCLES)) seq_inst
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .volt_ch1  (volt_ch1),
        .volt_ch2  (volt_ch2),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

endmodule

// File: hw/report_sequencer.sv
module report_sequencer
#(
    parameter int REPORT_CYCLES = 100_000_000
)
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  adc_pkg::millivolt_t  volt_ch1,
    input  adc_pkg::millivolt_t  volt_ch2,
    input  uart_pkg::uart_byte_t rx_data,
    input  logic                 rx_valid,
    output uart_pkg::uart_byte_t tx_data,
    output logic                 tx_valid,
    input  logic                 tx_ready
);

    localparam int WAIT_W = $clog2(REPORT_CYCLES + 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(REPORT_CYCLES - 1);
    localparam uart_pkg::char_idx_t LAST_IDX = uart_pkg::char_idx_t'(uart_pkg::REPORT_LEN - 1);

    uart_pkg::report_state_t state;
    uart_pkg::report_state_t state_d;
    uart_pkg::char_idx_t     char_idx;
    logic [WAIT_W-1:0]       wait_cnt;
    logic                    wait_done;
    logic                    tx_fire;
    adc_pkg::millivolt_t     v1_q;
    adc_pkg::millivolt_t     v2_q;

    function automatic uart_pkg::uart_byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10)
            return 8'h30 + {4'h0, nib}; // '0'..'9'
        else
            return 8'h37 + {4'h0, nib}; // 'A'..'F'
    endfunction

    function automatic uart_pkg::uart_byte_t report_char(
        input uart_pkg::char_idx_t idx,
        input adc_pkg::millivolt_t v1,
        input adc_pkg::millivolt_t v2
    );
        case (idx)
            4'd0:    return "A";
            4'd1:    return "1";
            4'd2:    return "=";
            4'd3:    return hex_char(v1[11:8]);
            4'd4:    return hex_char(v1[7:4]);
            4'd5:    return hex_char(v1[3:0]);
            4'd6:    return " ";
            4'd7:    return "A";
            4'd8:    return "2";
            4'd9:    return "=";
            4'd10:   return hex_char(v2[11:8]);
            4'd11:   return hex_char(v2[7:4]);
            4'd12:   return hex_char(v2[3:0]);
            4'd13:   return uart_pkg::CHAR_CR;
            default: return uart_pkg::CHAR_LF;
        endcase
    endfunction

    assign tx_fire   = tx_valid && tx_ready;
    assign wait_done = (wait_cnt == WAIT_LAST);

    always_comb
    begin
        state_d = state;
        case (state)
            uart_pkg::IDLE:
                state_d = uart_pkg::SEND;
            uart_pkg::SEND:
                if (tx_fire && char_idx == LAST_IDX)
                    state_d = uart_pkg::WAIT;
            uart_pkg::WAIT:
                if (wait_done && !tx_valid) // let a pending echo drain first
                    state_d = uart_pkg::SEND;
            default:
                state_d = uart_pkg::IDLE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            state <= uart_pkg::IDLE;
        else
            state <= state_d;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            wait_cnt <= '0;
        else if (state != uart_pkg::WAIT)
            wait_cnt <= '0;
        else if (!wait_done)
            wait_cnt <= wait_cnt + 1'b1;
    end

    // one snapshot per report line
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            v1_q <= '0;
            v2_q <= '0;
        end
        else if (state_d == uart_pkg::SEND && state != uart_pkg::SEND)
        begin
            v1_q <= volt_ch1;
            v2_q <= volt_ch2;
        end
    end

    // tx_data/tx_valid double as the echo hold register
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            tx_valid <= 1'b0;
            tx_data  <= '0;
            char_idx <= '0;
        end
        else if (tx_fire)
        begin
            tx_valid <= 1'b0;
            if (state == uart_pkg::SEND)
                char_idx <= (char_idx == LAST_IDX) ? '0 : char_idx + 1'b1;
        end
        else if (!tx_valid)
        begin
            if (state == uart_pkg::SEND)
            begin
                tx_data  <= report_char(char_idx, v1_q, v2_q);
                tx_valid <= 1'b1;
            end
            else if (state == uart_pkg::WAIT && state_d == uart_pkg::WAIT && rx_valid)
            begin
                tx_data  <= rx_data; // echo byte into the hold register
                tx_valid <= 1'b1;
            end
        end
    end

    a_tx_hold_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)))
        else $error("report_sequencer changed tx_data before handshake");

endmodule

// File: hw/adc_capture.sv
module adc_capture
#(
    parameter int SAMPLE_DIV = 100
)
(
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  adc_pkg::adc_code_t  ad1_in,
    input  adc_pkg::adc_code_t  ad2_in,
    output adc_pkg::millivolt_t volt_ch1,
    output adc_pkg::millivolt_t volt_ch2
);

    localparam int DIV_W = $clog2(SAMPLE_DIV + 1);

    logic [DIV_W-1:0]   div_cnt;
    logic               strobe;
    logic               code_vld;
    adc_pkg::adc_code_t code1_q;
    adc_pkg::adc_code_t code2_q;

    function automatic adc_pkg::millivolt_t code_to_mv(input adc_pkg::adc_code_t code);
        adc_pkg::mv_product_t prod;
        prod = adc_pkg::mv_product_t'(code) * adc_pkg::mv_product_t'(adc_pkg::FULL_SCALE_MV);
        return adc_pkg::millivolt_t'(prod >> adc_pkg::SCALE_SHIFT);
    endfunction

    assign strobe = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            div_cnt <= '0;
        else if (strobe)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // stage 1 grabs the pins
    always_ff @(posedge sys_clk)
    begin
        if (strobe)
        begin
            code1_q <= ad1_in;
            code2_q <= ad2_in;
        end
    end

    // stage 2 scales, outputs move two cycles after the strobe
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            code_vld <= 1'b0;
            volt_ch1 <= '0;
            volt_ch2 <= '0;
        end
        else
        begin
            code_vld <= strobe;
            if (code_vld)
            begin
                volt_ch1 <= code_to_mv(code1_q);
                volt_ch2 <= code_to_mv(code2_q);
            end
        end
    end

    a_mv_in_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (volt_ch1 <= adc_pkg::FULL_SCALE_MV) && (volt_ch2 <= adc_pkg::FULL_SCALE_MV))
        else $error("adc_capture millivolt output above full scale");

endmodule

// File: hw/uart_tx.sv
module uart_tx
#(
    parameter int CLKS_PER_BIT = 868
)
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  uart_pkg::uart_byte_t tx_data,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output logic                 tx_pin
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic
    {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;
    logic [9:0]       frame;   // stop, data msb..lsb, start

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            frame   <= '1; // line idles high
        end
        else if (state == TX_IDLE)
        begin
            if (tx_valid)
            begin
                frame   <= {1'b1, tx_data, 1'b0};
                state   <= TX_SEND;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end
        else if (clk_cnt == BIT_LAST)
        begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[9:1]}; // shift in idle level
            if (bit_idx == 4'd9)
                state <= TX_IDLE;
            else
                bit_idx <= bit_idx + 1'b1;
        end
        else
            clk_cnt <= clk_cnt + 1'b1;
    end

    assign tx_ready = (state == TX_IDLE);
    assign tx_pin   = frame[0];

    // the stop bit must be fully out before a new byte is taken
    a_idle_line_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tx_ready |-> tx_pin)
        else $error("uart_tx line low while ready");

endmodule

// File: hw/uart_rx.sv
module uart_rx
#(
    parameter int CLKS_PER_BIT = 868
)
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 rx_pin,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0]
    {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic [CNT_W-1:0]     clk_cnt;
    logic [2:0]           bit_idx;
    uart_pkg::uart_byte_t shift_q;

    // two flops against metastability, third one for edge detect
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx_pin;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE:
                begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (rx_prev && !rx_sync) // falling edge, maybe a start bit
                        state <= RX_START;
                end
                RX_START:
                begin
                    if (clk_cnt == HALF_LAST)
                    begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA; // glitch if high again
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                RX_DATA:
                begin
                    if (clk_cnt == BIT_LAST)
                    begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                RX_STOP:
                begin
                    if (clk_cnt == BIT_LAST)
                    begin
                        clk_cnt  <= '0;
                        rx_valid <= rx_sync; // bad stop bit drops the byte
                        state    <= RX_IDLE;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge sys_clk)
    begin
        if (state == RX_DATA && clk_cnt == BIT_LAST)
            shift_q <= {rx_sync, shift_q[7:1]};
    end

    assign rx_data = shift_q;

endmodule

// File: hw/adc_pkg.sv
package adc_pkg;

    localparam int ADC_CODE_BITS = 12;
    localparam int MV_BITS       = 12;

    // full scale input range of the converter
    localparam int FULL_SCALE_MV = 2000;

    // mv = code * FULL_SCALE_MV / 2^ADC_CODE_BITS, truncated
    localparam int SCALE_SHIFT = ADC_CODE_BITS;

    // 12-bit code times an 11-bit constant
    localparam int MV_PRODUCT_BITS = ADC_CODE_BITS + 11;

    typedef logic [ADC_CODE_BITS-1:0]   adc_code_t;
    typedef logic [MV_BITS-1:0]         millivolt_t;
    typedef logic [MV_PRODUCT_BITS-1:0] mv_product_t;

endpackage

// File: hw/uart_pkg.sv
package uart_pkg;

    // one serial data byte, also used for report characters
    typedef logic [7:0] uart_byte_t;

    // position of a character inside the report line
    typedef logic [3:0] char_idx_t;

    // report/echo sequencer states
    typedef enum logic [1:0]
    {
        IDLE,   // one cycle after reset
        SEND,   // report line in progress
        WAIT    // gap between reports, echo active
    } report_state_t;

    // "A1=hhh A2=hhh" plus cr lf
    localparam int REPORT_LEN = 15;

    localparam uart_byte_t CHAR_CR = 8'h0D;
    localparam uart_byte_t CHAR_LF = 8'h0A;

endpackage
